//--- verification/shiftCases.txt
// mode data serialIn steps expectedValue expectedToggles, all hex
// mode 0 hold 1 load 2 shl 3 shr 4 rol 5 ror, mode f ends the list
0 0000 0 00 0000 000
1 a5c3 0 00 a5c3 008
0 ffff 1 05 a5c3 000
1 0001 0 00 0001 007
2 0000 0 04 0010 008
3 0000 1 03 e002 009
2 0000 1 02 800b 008
1 ffff 0 00 ffff 00c
3 0000 0 10 0000 010
1 8001 0 00 8001 002
4 0000 0 01 0003 002
5 0000 0 02 c000 004
4 0000 0 00 c000 000
5 0000 1 00 c000 000
1 1234 0 00 1234 007
4 0000 0 10 1234 080
5 0000 0 04 4123 020
5 0000 0 10 4123 080
2 0000 1 10 ffff 035
3 0000 0 08 00ff 008
5 0000 0 01 807f 002
1 0000 0 00 0000 008
2 0000 0 03 0000 000
0 0000 0 00 0000 000
1 5555 0 00 5555 008
4 0000 0 03 aaaa 030
2 0000 1 01 5555 010
3 0000 1 02 d555 01f
f 0000 0 00 0000 000

//--- sources.f
+incdir+include
src/shiftPkg.sv
src/meterPkg.sv
src/shiftBus.sv
src/skidBuffer.sv
src/shiftControl.sv
src/shiftLane.sv
src/toggleCounter.sv
src/shiftTop.sv
verification/shiftTb.sv

//--- run.sh
#!/bin/sh
# compile and run the shift register testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBin=shiftSim

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  -f sources.f --top-module shiftTb \
  -Mdir "$buildDir" -o "$simBin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit "$status"
fi

"./$buildDir/$simBin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished cleanly"
exit 0

//--- verification/shiftTb.sv
/*
 * shift register testbench
 * replays the command cases under random back-pressure, checks every result
 */
`timescale 1ns/100ps
`default_nettype none

`include "shifter_defs.svh"

module shiftTb;
  import shiftPkg::*;
  import meterPkg::*;

  localparam int maxCases   = 40;
  localparam int fields     = 6;
  localparam int stallLimit = 400;

  logic                     CLK;
  logic                     oD;
  logic                     cmdValid;
  logic                     cmdReady;
  shiftMode_t               cmdMode;
  logic [`SHIFT_WIDTH-1:0]  cmdData;
  logic                     cmdSerial;
  logic [`STEP_WIDTH-1:0]   cmdSteps;
  logic                     resValid;
  logic                     resReady;
  logic [`SHIFT_WIDTH-1:0]  resValue;
  toggleCount_t             resToggles;

  // six words per case as laid out in the case file
  logic [15:0]              caseMem [0:maxCases*fields-1];
  logic [`SHIFT_WIDTH-1:0]  expValue [0:maxCases-1];
  toggleCount_t             expToggles [0:maxCases-1];
  int                       numCases;
  int                       received;
  logic                     extraResult;
  logic [15:0]              lfsr;

  shiftTop u_dut (
    .CLK(CLK), .oD(oD),
    .cmdValid(cmdValid), .cmdReady(cmdReady), .cmdMode(cmdMode),
    .cmdData(cmdData), .cmdSerial(cmdSerial), .cmdSteps(cmdSteps),
    .resValid(resValid), .resReady(resReady),
    .resValue(resValue), .resToggles(resToggles)
  );

  // 20 ns period
  always #10 CLK = ~CLK;

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one step per bit taken
  task automatic drawBit(output logic b);
    lfsr = lfsrNext(lfsr);
    b = lfsr[0];
  endtask

  function automatic int countBits(input logic [`SHIFT_WIDTH-1:0] v);
    int n;
    n = 0;
    for (int i = 0; i < `SHIFT_WIDTH; i++) begin
      n += int'(v[i]);
    end
    return n;
  endfunction

  // reference behavior of one register update
  function automatic logic [`SHIFT_WIDTH-1:0] modelStep(
    input shiftMode_t               mode,
    input logic [`SHIFT_WIDTH-1:0]  q,
    input logic [`SHIFT_WIDTH-1:0]  data,
    input logic                     serial
  );
    case (mode)
      MODE_LOAD: return data;
      MODE_SHL:  return {q[`SHIFT_WIDTH-2:0], serial};
      MODE_SHR:  return {serial, q[`SHIFT_WIDTH-1:1]};
      MODE_ROL:  return {q[`SHIFT_WIDTH-2:0], q[`SHIFT_WIDTH-1]};
      MODE_ROR:  return {q[0], q[`SHIFT_WIDTH-1:1]};
      default:   return q;
    endcase
  endfunction

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [`SHIFT_WIDTH-1:0] got,
                            input logic [`SHIFT_WIDTH-1:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkToggles(input string name, input toggleCount_t got,
                              input toggleCount_t exp);
    if (got !== exp) begin
      stopOnError($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkState(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  // read cases, rebuild each expectation and hold the file to it
  task automatic loadCases();
    logic [`SHIFT_WIDTH-1:0] q;
    logic [`SHIFT_WIDTH-1:0] nextQ;
    shiftMode_t              mode;
    int                      tog;
    int                      steps;
    int                      base;
    $readmemh("verification/shiftCases.txt", caseMem);
    numCases = -1;
    for (int i = 0; i < maxCases && numCases < 0; i++) begin
      if (caseMem[i*fields] == 16'h000f) begin
        numCases = i;
      end
    end
    if (numCases <= 0) begin
      stopOnError("case file holds no cases or lacks its end marker");
    end
    // register starts from reset
    q = '0;
    for (int i = 0; i < numCases; i++) begin
      base = i * fields;
      if (caseMem[base] > 16'd5 || caseMem[base+3] > 16'd16) begin
        stopOnError($sformatf("case %0d has an unknown mode or too many steps", i));
      end
      mode  = shiftMode_t'(caseMem[base][2:0]);
      // load and hold update once
      steps = (mode == MODE_LOAD || mode == MODE_HOLD) ? 1 : int'(caseMem[base+3]);
      tog   = 0;
      for (int s = 0; s < steps; s++) begin
        nextQ = modelStep(mode, q, caseMem[base+1], caseMem[base+2][0]);
        tog  += countBits(q ^ nextQ);
        q     = nextQ;
      end
      expValue[i]   = q;
      expToggles[i] = toggleCount_t'(tog);
      checkValue($sformatf("case %0d file value", i), caseMem[base+4], q);
      checkToggles($sformatf("case %0d file toggles", i),
                   caseMem[base+5][`TOGGLE_WIDTH-1:0], expToggles[i]);
    end
  endtask

  task automatic resetAndIdle();
    int waited;
    repeat (5) begin
      @(negedge CLK);
      checkState("cmdReady in reset", cmdReady, 1'b0);
      checkState("resValid in reset", resValid, 1'b0);
    end
    oD = 1'b1;
    waited = 0;
    while (cmdReady !== 1'b1) begin
      @(negedge CLK);
      checkState("resValid after reset", resValid, 1'b0);
      waited++;
      if (waited > 20) begin
        stopOnError("cmdReady did not rise after reset");
      end
    end
    // idle with no command
    repeat (3) begin
      @(negedge CLK);
      checkState("cmdReady while idle", cmdReady, 1'b1);
      checkState("resValid while idle", resValid, 1'b0);
    end
  endtask

  // both channels stepped together on each falling edge
  task automatic runCases();
    int   sendIdx;
    int   stall;
    int   blocked;
    int   base;
    logic accepted;
    logic readyBit;
    logic gapBit;
    sendIdx  = 0;
    stall    = 0;
    blocked  = 0;
    accepted = 1'b0;
    while (received < numCases) begin
      @(negedge CLK);
      drawBit(readyBit);
      drawBit(gapBit);
      // command taken on the last rising edge
      if (accepted) begin
        sendIdx++;
        cmdValid = 1'b0;
      end
      if (!cmdValid && sendIdx < numCases && !gapBit) begin
        base      = sendIdx * fields;
        cmdMode   = shiftMode_t'(caseMem[base][2:0]);
        cmdData   = caseMem[base+1];
        cmdSerial = caseMem[base+2][0];
        cmdSteps  = caseMem[base+3][`STEP_WIDTH-1:0];
        cmdValid  = 1'b1;
      end
      // ready is stable up to the next rising edge
      accepted = cmdValid && cmdReady;
      blocked  = (cmdValid && !accepted) ? blocked + 1 : 0;
      if (blocked > stallLimit) begin
        stopOnError("command held too long without cmdReady");
      end
      resReady = readyBit;
      if (resValid && resReady) begin
        if (received >= sendIdx) begin
          stopOnError("result arrived with no command outstanding");
        end
        checkValue("resValue", resValue, expValue[received]);
        checkToggles("resToggles", resToggles, expToggles[received]);
        received++;
        stall = 0;
      end else begin
        stall++;
        if (stall > stallLimit) begin
          stopOnError("timed out waiting for a result");
        end
      end
    end
    cmdValid = 1'b0;
  endtask

  // no further result may show up
  task automatic checkQuiet(output logic extra);
    resReady = 1'b1;
    extra    = 1'b0;
    repeat (30) begin
      @(negedge CLK);
      if (resValid) begin
        extra = 1'b1;
      end
    end
  endtask

  initial begin
    CLK       = 1'b0;
    oD        = 1'b0;
    cmdValid  = 1'b0;
    cmdMode   = MODE_HOLD;
    cmdData   = '0;
    cmdSerial = 1'b0;
    cmdSteps  = '0;
    resReady  = 1'b0;
    lfsr      = 16'd88;
    received  = 0;
    loadCases();
    resetAndIdle();
    runCases();
    checkQuiet(extraResult);
    if (!extraResult) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stopOnError("a result arrived after every command had been answered");
    end
  end

endmodule

`default_nettype wire

//--- src/shiftTop.sv
/*
 * universal shift register with activity metering
 * command and result channels buffered, controller, lane and meter on one bus
 */
`timescale 1ns/100ps
`default_nettype none

`include "shifter_defs.svh"

module shiftTop (
  input  wire logic                     CLK,
  input  wire logic                     oD,
  input  wire logic                     cmdValid,
  output logic                          cmdReady,
  input  wire shiftPkg::shiftMode_t     cmdMode,
  input  wire logic [`SHIFT_WIDTH-1:0]  cmdData,
  input  wire logic                     cmdSerial,
  input  wire logic [`STEP_WIDTH-1:0]   cmdSteps,
  output logic                          resValid,
  input  wire logic                     resReady,
  output logic [`SHIFT_WIDTH-1:0]       resValue,
  output meterPkg::toggleCount_t        resToggles
);
  import shiftPkg::*;

  shiftCmd_t     cmdIn;
  shiftCmd_t     cmdOut;
  logic          cmdOutValid;
  logic          cmdOutReady;
  shiftResult_t  resIn;
  shiftResult_t  resOut;
  logic          resInValid;
  logic          resInReady;

  shiftBus bus ();

  assign cmdIn = '{mode: cmdMode, data: cmdData, serialIn: cmdSerial, steps: cmdSteps};

  // command side
  skidBuffer #(.payload_t(shiftCmd_t)) u_cmdBuf (
    .CLK(CLK), .oD(oD),
    .inValid(cmdValid), .inReady(cmdReady), .inData(cmdIn),
    .outValid(cmdOutValid), .outReady(cmdOutReady), .outData(cmdOut)
  );

  shiftControl u_ctrl (
    .CLK(CLK), .oD(oD),
    .cmdValid(cmdOutValid), .cmdReady(cmdOutReady), .cmd(cmdOut),
    .resValid(resInValid), .resReady(resInReady), .result(resIn),
    .bus(bus.ctrl)
  );

  shiftLane u_lane (.CLK(CLK), .oD(oD), .bus(bus.lane));

  toggleCounter u_meter (.CLK(CLK), .oD(oD), .bus(bus.meter));

  // result side, queues under back-pressure
  skidBuffer #(.payload_t(shiftResult_t)) u_resBuf (
    .CLK(CLK), .oD(oD),
    .inValid(resInValid), .inReady(resInReady), .inData(resIn),
    .outValid(resValid), .outReady(resReady), .outData(resOut)
  );

  assign resValue   = resOut.value;
  assign resToggles = resOut.toggles;

endmodule

`default_nettype wire

//--- src/toggleCounter.sv
/*
 * toggle meter
 * sums bit flips between successive register values per command
 */
`timescale 1ns/100ps
`default_nettype none

`include "shifter_defs.svh"

module toggleCounter (
  input  wire logic  CLK,
  input  wire logic  oD,
  shiftBus.meter     bus
);
  import meterPkg::*;

  logic [`SHIFT_WIDTH-1:0] prevQ;
  logic [`SHIFT_WIDTH-1:0] flips;
  toggleCount_t            count;

  // bits that changed on the last update
  assign flips = bus.q ^ prevQ;

  always_ff @(posedge CLK or negedge oD) begin
    if (!oD) begin
      prevQ <= '0;
      count <= '0;
    end else begin
      prevQ <= bus.q;
      if (bus.clear) begin
        count <= '0;
      end else begin
        // counted one cycle after the step
        count <= count + toggleCount_t'($countones(flips));
      end
    end
  end

  assign bus.toggles = count;

  // only clear brings the count down
  countMonotonic: assert property (@(posedge CLK) disable iff (!oD)
    !bus.clear |=> bus.toggles >= $past(bus.toggles));

endmodule

`default_nettype wire

//--- src/shiftLane.sv
/*
 * 16-bit universal shift register
 * per-bit selection of neighbor, end fill and load data, clocked on step
 */
`timescale 1ns/100ps
`default_nettype none

`include "shifter_defs.svh"

module shiftLane (
  input  wire logic  CLK,
  input  wire logic  oD,
  shiftBus.lane      bus
);
  import shiftPkg::*;

  localparam int width = `SHIFT_WIDTH;

  logic [width-1:0] q;
  logic [width-1:0] nextQ;
  logic             dirLeft;
  logic             rotate;
  logic             load;
  logic             hold;
  logic             fillLow;
  logic             fillHigh;

  // mode decode
  assign dirLeft = (bus.mode == MODE_SHL) || (bus.mode == MODE_ROL);
  assign rotate  = (bus.mode == MODE_ROL) || (bus.mode == MODE_ROR);
  assign load    = (bus.mode == MODE_LOAD);
  assign hold    = (bus.mode == MODE_HOLD);

  // end bits take serial input or wrap around
  assign fillLow  = rotate ? q[width-1] : bus.serialIn;
  assign fillHigh = rotate ? q[0] : bus.serialIn;

  for (genvar i = 0; i < width; i++) begin : gSlice
    logic moved;
    if (i == 0) begin : gRight
      // lsb slice, fill enters on a left move
      assign moved = dirLeft ? fillLow : q[1];
    end else if (i == width - 1) begin : gLeft
      // msb slice, fill enters on a right move
      assign moved = dirLeft ? q[i-1] : fillHigh;
    end else begin : gMid
      assign moved = dirLeft ? q[i-1] : q[i+1];
    end
    // load wins over the move
    assign nextQ[i] = load ? bus.loadData[i] : (hold ? q[i] : moved);
  end

  always_ff @(posedge CLK or negedge oD) begin
    if (!oD) begin
      q <= '0;
    end else if (bus.step) begin
      q <= nextQ;
    end
  end

  assign bus.q = q;

endmodule

`default_nettype wire

//--- src/shiftControl.sv
/*
 * shift register controller
 * takes a command, paces the steps, waits for the meter, then reports
 */
`timescale 1ns/100ps
`default_nettype none

`include "shifter_defs.svh"

module shiftControl (
  input  wire logic                   CLK,
  input  wire logic                   oD,
  input  wire logic                   cmdValid,
  output logic                        cmdReady,
  input  wire shiftPkg::shiftCmd_t    cmd,
  output logic                        resValid,
  input  wire logic                   resReady,
  output shiftPkg::shiftResult_t      result,
  shiftBus.ctrl                       bus
);
  import shiftPkg::*;
  import meterPkg::*;

  localparam logic [`STEP_WIDTH-1:0] oneStep = 1;

  ctrlState_t               state;
  logic [`STEP_WIDTH-1:0]   remaining;
  logic [`STEP_WIDTH-1:0]   effSteps;
  logic                     stepQ;
  logic                     resValidQ;
  logic                     accept;
  shiftMode_t               modeQ;
  logic [`SHIFT_WIDTH-1:0]  dataQ;
  logic                     serialQ;
  shiftResult_t             resultQ;

  assign cmdReady = (state == ST_IDLE);
  assign accept   = cmdValid && cmdReady;

  // load and hold are single updates
  assign effSteps = (cmd.mode == MODE_LOAD || cmd.mode == MODE_HOLD) ? oneStep : cmd.steps;

  always_ff @(posedge CLK or negedge oD) begin
    if (!oD) begin
      state     <= ST_IDLE;
      remaining <= '0;
      stepQ     <= 1'b0;
      resValidQ <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            remaining <= effSteps;
            stepQ     <= (effSteps != '0);
            // zero-step shift or rotate goes straight to report
            state     <= (effSteps != '0) ? ST_RUN : ST_REPORT;
          end
        end
        ST_RUN: begin
          if (stepQ) begin
            remaining <= remaining - 1'b1;
            stepQ     <= (remaining != oneStep);
          end else begin
            // one idle cycle so the meter counts the last step
            state <= ST_REPORT;
          end
        end
        ST_REPORT: begin
          if (!resValidQ) begin
            resValidQ <= 1'b1;
          end else if (resReady) begin
            resValidQ <= 1'b0;
            state     <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // latched command and result words
  always_ff @(posedge CLK) begin
    if (accept) begin
      modeQ   <= cmd.mode;
      dataQ   <= cmd.data;
      serialQ <= cmd.serialIn;
    end
    if (state == ST_REPORT && !resValidQ) begin
      resultQ <= '{value: bus.q, toggles: bus.toggles};
    end
  end

  assign bus.step     = stepQ;
  assign bus.clear    = accept;
  assign bus.mode     = modeQ;
  assign bus.serialIn = serialQ;
  assign bus.loadData = dataQ;
  assign resValid     = resValidQ;
  assign result       = resultQ;

  stepOnlyInRun: assert property (@(posedge CLK) disable iff (!oD)
    bus.step |-> state == ST_RUN);

  // no new command while a run or a report is pending
  readyOnlyIdle: assert property (@(posedge CLK) disable iff (!oD)
    cmdReady |-> !bus.step && !resValidQ);

endmodule

`default_nettype wire

//--- src/skidBuffer.sv
/*
 * two-entry valid/ready skid buffer
 * main slot drives the output, skid slot catches data while the output stalls
 */
`timescale 1ns/100ps
`default_nettype none

`include "shifter_defs.svh"

module skidBuffer #(
  parameter type payload_t = logic [`SHIFT_WIDTH-1:0]
) (
  input  wire logic      CLK,
  input  wire logic      oD,
  input  wire logic      inValid,
  output logic           inReady,
  input  wire payload_t  inData,
  output logic           outValid,
  input  wire logic      outReady,
  output payload_t       outData
);

  payload_t mainData;
  payload_t skidData;
  logic     mainValid;
  logic     skidValid;
  logic     readyQ;
  logic     inFire;
  logic     outFire;
  logic     refill;

  assign inFire  = inValid && readyQ;
  assign outFire = mainValid && outReady;
  // main slot can take a word this cycle
  assign refill  = outFire || !mainValid;

  // ready is registered, low in reset and whenever the skid slot holds data
  always_ff @(posedge CLK or negedge oD) begin
    if (!oD) begin
      mainValid <= 1'b0;
      skidValid <= 1'b0;
      readyQ    <= 1'b0;
    end else if (refill) begin
      mainValid <= skidValid || inFire;
      skidValid <= 1'b0;
      readyQ    <= 1'b1;
    end else begin
      skidValid <= skidValid || inFire;
      readyQ    <= !(skidValid || inFire);
    end
  end

  always_ff @(posedge CLK) begin
    // skid word goes first to keep order
    if (refill && (skidValid || inFire)) begin
      mainData <= skidValid ? skidData : inData;
    end
    if (!refill && inFire) begin
      skidData <= inData;
    end
  end

  assign inReady  = readyQ;
  assign outValid = mainValid;
  assign outData  = mainData;

  // stalled output word must not change before it is taken
  outHoldStable: assert property (@(posedge CLK) disable iff (!oD)
    outValid && !outReady |=> outValid && $stable(outData));

endmodule

`default_nettype wire

//--- src/shiftBus.sv
/*
 * internal shift bus
 * joins the controller, the register lane and the toggle meter
 */
`timescale 1ns/100ps
`default_nettype none

`include "shifter_defs.svh"

interface shiftBus;
  import shiftPkg::*;
  import meterPkg::*;

  // one register update per cycle while high
  logic                     step;
  shiftMode_t               mode;
  logic                     serialIn;
  logic [`SHIFT_WIDTH-1:0]  loadData;
  // zeroes the meter at command start
  logic                     clear;
  logic [`SHIFT_WIDTH-1:0]  q;
  toggleCount_t             toggles;

  modport ctrl  (output step, mode, serialIn, loadData, clear, input q, toggles);
  modport lane  (input step, mode, serialIn, loadData, output q);
  modport meter (input clear, q, output toggles);

endinterface

`default_nettype wire

//--- src/meterPkg.sv
/*
 * activity metering types
 * toggle count and controller states
 */
`default_nettype none

`include "shifter_defs.svh"

package meterPkg;

  // bit flips over one command
  typedef logic [`TOGGLE_WIDTH-1:0] toggleCount_t;

  // controller sequence
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_RUN    = 2'd1,
    ST_REPORT = 2'd2
  } ctrlState_t;

endpackage

`default_nettype wire

//--- src/shiftPkg.sv
/*
 * shift register command types
 * operating modes plus the command and result words of both channels
 */
`default_nettype none

`include "shifter_defs.svh"

package shiftPkg;

  // register operation per step
  typedef enum logic [2:0] {
    MODE_HOLD = 3'd0,
    MODE_LOAD = 3'd1,
    MODE_SHL  = 3'd2,
    MODE_SHR  = 3'd3,
    MODE_ROL  = 3'd4,
    MODE_ROR  = 3'd5
  } shiftMode_t;

  // command word, 25 bits
  typedef struct packed {
    shiftMode_t                mode;
    logic [`SHIFT_WIDTH-1:0]   data;
    logic                      serialIn;
    logic [`STEP_WIDTH-1:0]    steps;
  } shiftCmd_t;

  // result word, 25 bits
  typedef struct packed {
    logic [`SHIFT_WIDTH-1:0]   value;
    logic [`TOGGLE_WIDTH-1:0]  toggles;
  } shiftResult_t;

endpackage

`default_nettype wire

//--- include/shifter_defs.svh
/*
 * shift register sizing
 * widths of the register word, the step count and the toggle count
 */
`ifndef SHIFTER_DEFS_SVH
`define SHIFTER_DEFS_SVH

// register word
`define SHIFT_WIDTH 16

// step count, 0 to 16 steps
`define STEP_WIDTH 5

// toggle count, 16 bits times 16 steps at most
`define TOGGLE_WIDTH 9

`endif
